// File: Makefile
TOP := fabric_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --assert -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: project.f
src/fabric_map_pkg.sv
src/fabric_bus_pkg.sv
src/tcm_ram.sv
src/tcm_ctrl.sv
src/cpu2icb_bridge.sv
src/mem_fabric_top.sv
tests/fabric_properties.sv
tests/fabric_tb.sv

// File: src/cpu2icb_bridge.sv
`timescale 1ns/1ps

module cpu2icb_bridge #(
    // Decoded window of this bus
    parameter fabric_bus_pkg::addr_t ADDR_BASE = fabric_map_pkg::PD_BASE,
    parameter fabric_bus_pkg::addr_t ADDR_MASK = fabric_map_pkg::PD_MASK
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // CPU side
    input  fabric_bus_pkg::mem_req_t cpu_req_i,
    output fabric_bus_pkg::mem_rsp_t cpu_rsp_o,

    // ICB side
    output fabric_bus_pkg::icb_cmd_t icb_cmd_o,
    input  logic                    icb_cmd_ready_i,
    input  fabric_bus_pkg::icb_rsp_t icb_rsp_i
);

    // Request falls in this window
    logic cpu_hit;

    // Registered response
    logic                  rvalid_q;
    fabric_bus_pkg::data_t rdata_q;
    logic                  err_q;

    // ----------------------------------------
    // Command path
    // ----------------------------------------

    assign cpu_hit = cpu_req_i.req & fabric_map_pkg::addr_hit(cpu_req_i.addr,
        ADDR_BASE, ADDR_MASK);

    // Valid follows the request combinationally
    assign icb_cmd_o.valid = cpu_hit;
    assign icb_cmd_o.read  = ~cpu_req_i.we;
    assign icb_cmd_o.addr  = cpu_req_i.addr;
    assign icb_cmd_o.wdata = cpu_req_i.wdata;
    assign icb_cmd_o.wmask = cpu_req_i.be;

    // Grant on the ICB transfer
    // Ready low leaves the master holding its request
    assign cpu_rsp_o.gnt = icb_cmd_o.valid & icb_cmd_ready_i;

    // ----------------------------------------
    // Response path
    // ----------------------------------------

    // ICB responses come back in order and are always taken
    // Data and err read as zero outside a response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
            err_q    <= 1'b0;
        end else begin
            rvalid_q <= icb_rsp_i.valid;
            if (icb_rsp_i.valid) begin
                rdata_q <= icb_rsp_i.rdata;
                err_q   <= icb_rsp_i.err;
            end else begin
                rdata_q <= '0;
                err_q   <= 1'b0;
            end
        end
    end

    // One cycle behind the ICB response
    assign cpu_rsp_o.rvalid = rvalid_q;
    assign cpu_rsp_o.rdata  = rdata_q;
    assign cpu_rsp_o.err    = err_q;

endmodule

// File: src/fabric_bus_pkg.sv
package fabric_bus_pkg;

    // ----------------------------------------
    // Widths with a meaning
    // ----------------------------------------

    // 32-bit data word, one strobe per byte
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [fabric_map_pkg::ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0]                 data_t;
    typedef logic [STRB_W-1:0]                 strb_t;

    // Word index inside the TCM, address bits 14 down to 2
    typedef logic [fabric_map_pkg::TCM_AWIDTH-fabric_map_pkg::TCM_IDX_LSB-1:0] tcm_index_t;

    // ----------------------------------------
    // CPU side req/gnt/rvalid
    // ----------------------------------------

    // Held stable by the master until gnt
    typedef struct packed {
        logic  req;
        logic  we;
        strb_t be;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // gnt same cycle, rvalid one or more cycles later
    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        data_t rdata;
        logic  err;
    } mem_rsp_t;

    // ----------------------------------------
    // ICB valid/ready
    // ----------------------------------------

    // Transfers on valid and ready
    typedef struct packed {
        logic  valid;
        logic  read;
        addr_t addr;
        data_t wdata;
        strb_t wmask;
    } icb_cmd_t;

    // Response side is always accepted, so there is no ready
    typedef struct packed {
        logic  valid;
        data_t rdata;
        logic  err;
    } icb_rsp_t;

endpackage

// File: src/fabric_map_pkg.sv
package fabric_map_pkg;

    // ----------------------------------------
    // Address geometry
    // ----------------------------------------

    // Byte address width on every bus
    localparam int ADDR_W = 32;

    // Word offset inside the TCM, 32-bit words
    localparam int TCM_IDX_LSB = 2;

    // ----------------------------------------
    // TCM window
    // ----------------------------------------

    localparam logic [ADDR_W-1:0] TCM_BASE = 32'h8000_0000;
    // Low address bits decoded inside the TCM, 32 KiB
    localparam int TCM_AWIDTH = 15;
    // All ones in the low TCM_AWIDTH bits
    localparam logic [ADDR_W-1:0] TCM_MASK = {{(ADDR_W-TCM_AWIDTH){1'b0}}, {TCM_AWIDTH{1'b1}}};
    // Number of 32-bit words, 8192
    localparam int TCM_DEPTH = 2 ** (TCM_AWIDTH - TCM_IDX_LSB);

    // ----------------------------------------
    // ICB peripheral windows
    // ----------------------------------------

    // Instruction ICB, 0x2000_0000 to 0x3fff_ffff
    localparam logic [ADDR_W-1:0] PI_BASE = 32'h2000_0000;
    localparam logic [ADDR_W-1:0] PI_MASK = 32'h1fff_ffff;
    // Data ICB, 0x1000_0000 to 0x1fff_ffff
    localparam logic [ADDR_W-1:0] PD_BASE = 32'h1000_0000;
    localparam logic [ADDR_W-1:0] PD_MASK = 32'h0fff_ffff;

    // Window hit: bits above the mask must match the base
    function automatic logic addr_hit(logic [ADDR_W-1:0] addr, logic [ADDR_W-1:0] base,
                                      logic [ADDR_W-1:0] mask);
        return (addr & ~mask) == (base & ~mask);
    endfunction

endpackage

// File: src/mem_fabric_top.sv
`timescale 1ns/1ps

module mem_fabric_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // Masters
    input  fabric_bus_pkg::mem_req_t instr_req_i,
    input  fabric_bus_pkg::mem_req_t data_req_i,
    output fabric_bus_pkg::mem_rsp_t instr_rsp_o,
    output fabric_bus_pkg::mem_rsp_t data_rsp_o,

    // Instruction peripheral ICB
    output fabric_bus_pkg::icb_cmd_t pi_cmd_o,
    input  logic                    pi_cmd_ready_i,
    input  fabric_bus_pkg::icb_rsp_t pi_rsp_i,

    // Data peripheral ICB
    output fabric_bus_pkg::icb_cmd_t pd_cmd_o,
    input  logic                    pd_cmd_ready_i,
    input  fabric_bus_pkg::icb_rsp_t pd_rsp_i
);

    // Per target responses
    fabric_bus_pkg::mem_rsp_t tcm_instr_rsp;
    fabric_bus_pkg::mem_rsp_t tcm_data_rsp;
    fabric_bus_pkg::mem_rsp_t pi_instr_rsp;
    fabric_bus_pkg::mem_rsp_t pd_data_rsp;

    // OR merge of two targets serving one master
    // Data gated by its own rvalid so an idle target adds nothing
    function automatic fabric_bus_pkg::mem_rsp_t merge_rsp(fabric_bus_pkg::mem_rsp_t x,
                                                          fabric_bus_pkg::mem_rsp_t y);
        fabric_bus_pkg::mem_rsp_t m;
        m.gnt    = x.gnt | y.gnt;
        m.rvalid = x.rvalid | y.rvalid;
        m.rdata  = (x.rdata & {fabric_bus_pkg::DATA_W{x.rvalid}}) |
                   (y.rdata & {fabric_bus_pkg::DATA_W{y.rvalid}});
        m.err    = x.err | y.err;
        return m;
    endfunction

    // ----------------------------------------
    // Shared TCM
    // ----------------------------------------

    // Both masters, fixed one-cycle latency
    tcm_ctrl u_tcm (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_req_i (instr_req_i),
        .data_req_i  (data_req_i),
        .instr_rsp_o (tcm_instr_rsp),
        .data_rsp_o  (tcm_data_rsp)
    );

    // ----------------------------------------
    // Peripheral bridges
    // ----------------------------------------

    // Instruction master to the PI window
    cpu2icb_bridge #(
        .ADDR_BASE (fabric_map_pkg::PI_BASE),
        .ADDR_MASK (fabric_map_pkg::PI_MASK)
    ) u_pi_bridge (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_req_i       (instr_req_i),
        .cpu_rsp_o       (pi_instr_rsp),
        .icb_cmd_o       (pi_cmd_o),
        .icb_cmd_ready_i (pi_cmd_ready_i),
        .icb_rsp_i       (pi_rsp_i)
    );

    // Data master to the PD window
    cpu2icb_bridge #(
        .ADDR_BASE (fabric_map_pkg::PD_BASE),
        .ADDR_MASK (fabric_map_pkg::PD_MASK)
    ) u_pd_bridge (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_req_i       (data_req_i),
        .cpu_rsp_o       (pd_data_rsp),
        .icb_cmd_o       (pd_cmd_o),
        .icb_cmd_ready_i (pd_cmd_ready_i),
        .icb_rsp_i       (pd_rsp_i)
    );

    // ----------------------------------------
    // Response merge per master
    // ----------------------------------------

    // Unmapped addresses hit nothing and stay ungranted
    assign instr_rsp_o = merge_rsp(tcm_instr_rsp, pi_instr_rsp);
    assign data_rsp_o  = merge_rsp(tcm_data_rsp, pd_data_rsp);

endmodule

// File: src/tcm_ctrl.sv
`timescale 1ns/1ps

module tcm_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,

    input  fabric_bus_pkg::mem_req_t instr_req_i,
    input  fabric_bus_pkg::mem_req_t data_req_i,
    output fabric_bus_pkg::mem_rsp_t instr_rsp_o,
    output fabric_bus_pkg::mem_rsp_t data_rsp_o
);

    // Window hits per master
    logic instr_hit;
    logic data_hit;

    // Byte writes, only on a write request
    fabric_bus_pkg::strb_t instr_wstrb;
    fabric_bus_pkg::strb_t data_wstrb;

    // RAM output words
    fabric_bus_pkg::data_t instr_rdata;
    fabric_bus_pkg::data_t data_rdata;

    // One-cycle response valids
    logic instr_rvalid_q;
    logic data_rvalid_q;

    // ----------------------------------------
    // Decode and grant
    // ----------------------------------------

    assign instr_hit = instr_req_i.req & fabric_map_pkg::addr_hit(instr_req_i.addr,
        fabric_map_pkg::TCM_BASE, fabric_map_pkg::TCM_MASK);
    assign data_hit  = data_req_i.req & fabric_map_pkg::addr_hit(data_req_i.addr,
        fabric_map_pkg::TCM_BASE, fabric_map_pkg::TCM_MASK);

    assign instr_wstrb = {fabric_bus_pkg::STRB_W{instr_req_i.we}} & instr_req_i.be;
    assign data_wstrb  = {fabric_bus_pkg::STRB_W{data_req_i.we}} & data_req_i.be;

    // ----------------------------------------
    // RAM, port A instruction, port B data
    // ----------------------------------------

    tcm_ram u_ram (
        .clk       (clk),
        .a_en_i    (instr_hit),
        .a_we_i    (instr_wstrb),
        .a_index_i (instr_req_i.addr[fabric_map_pkg::TCM_AWIDTH-1:fabric_map_pkg::TCM_IDX_LSB]),
        .a_wdata_i (instr_req_i.wdata),
        .a_rdata_o (instr_rdata),
        .b_en_i    (data_hit),
        .b_we_i    (data_wstrb),
        .b_index_i (data_req_i.addr[fabric_map_pkg::TCM_AWIDTH-1:fabric_map_pkg::TCM_IDX_LSB]),
        .b_wdata_i (data_req_i.wdata),
        .b_rdata_o (data_rdata)
    );

    // Every access, reads and writes alike, answers in the next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_hit;
            data_rvalid_q  <= data_hit;
        end
    end

    // No back-pressure, grant in the request cycle
    assign instr_rsp_o.gnt    = instr_hit;
    assign instr_rsp_o.rvalid = instr_rvalid_q;
    assign instr_rsp_o.rdata  = instr_rdata;
    assign instr_rsp_o.err    = 1'b0;

    assign data_rsp_o.gnt     = data_hit;
    assign data_rsp_o.rvalid  = data_rvalid_q;
    assign data_rsp_o.rdata   = data_rdata;
    assign data_rsp_o.err     = 1'b0;

endmodule

// File: src/tcm_ram.sv
`timescale 1ns/1ps

module tcm_ram (
    input  logic                      clk,

    // Port A, instruction master
    input  logic                      a_en_i,
    input  fabric_bus_pkg::strb_t      a_we_i,
    input  fabric_bus_pkg::tcm_index_t a_index_i,
    input  fabric_bus_pkg::data_t      a_wdata_i,
    output fabric_bus_pkg::data_t      a_rdata_o,

    // Port B, data master
    input  logic                      b_en_i,
    input  fabric_bus_pkg::strb_t      b_we_i,
    input  fabric_bus_pkg::tcm_index_t b_index_i,
    input  fabric_bus_pkg::data_t      b_wdata_i,
    output fabric_bus_pkg::data_t      b_rdata_o
);

    // Word array, zero at time zero
    fabric_bus_pkg::data_t mem_q [fabric_map_pkg::TCM_DEPTH] = '{default: '0};

    // Both ports in one process so the array has a single writer
    always_ff @(posedge clk) begin
        // Port A read of the old word, then byte writes
        if (a_en_i) begin
            a_rdata_o <= mem_q[a_index_i];
            for (int i = 0; i < fabric_bus_pkg::STRB_W; i++) begin
                if (a_we_i[i]) begin
                    mem_q[a_index_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
                end
            end
        end
        // Port B, same scheme
        if (b_en_i) begin
            b_rdata_o <= mem_q[b_index_i];
            for (int i = 0; i < fabric_bus_pkg::STRB_W; i++) begin
                if (b_we_i[i]) begin
                    mem_q[b_index_i][8*i +: 8] <= b_wdata_i[8*i +: 8];
                end
            end
        end
        // Disabled port keeps its last read word
    end

endmodule

// File: tests/fabric_properties.sv
`timescale 1ns/1ps

module fabric_properties (
    input logic                     clk,
    input logic                     rst_n,
    input fabric_bus_pkg::mem_req_t instr_req_i,
    input fabric_bus_pkg::mem_req_t data_req_i,
    input fabric_bus_pkg::mem_rsp_t instr_rsp_o,
    input fabric_bus_pkg::mem_rsp_t data_rsp_o,
    input fabric_bus_pkg::icb_cmd_t pi_cmd_o,
    input logic                     pi_cmd_ready_i,
    input fabric_bus_pkg::icb_cmd_t pd_cmd_o,
    input logic                     pd_cmd_ready_i
);

    // Requests inside the TCM window
    logic instr_tcm;
    logic data_tcm;

    assign instr_tcm = instr_req_i.req &&
        (instr_req_i.addr & ~fabric_map_pkg::TCM_MASK) == fabric_map_pkg::TCM_BASE;
    assign data_tcm  = data_req_i.req &&
        (data_req_i.addr & ~fabric_map_pkg::TCM_MASK) == fabric_map_pkg::TCM_BASE;

    // ----------------------------------------
    // TCM answers one cycle after grant
    // ----------------------------------------

    a_instr_tcm_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        instr_tcm && instr_rsp_o.gnt |=> instr_rsp_o.rvalid)
        else $error("instr TCM grant not followed by rvalid");

    a_data_tcm_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        data_tcm && data_rsp_o.gnt |=> data_rsp_o.rvalid)
        else $error("data TCM grant not followed by rvalid");

    // Stalled ICB command holds its address
    a_pi_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pi_cmd_o.valid && !pi_cmd_ready_i |=> $stable(pi_cmd_o.addr))
        else $error("pi_cmd_o.addr changed while stalled");

    a_pd_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pd_cmd_o.valid && !pd_cmd_ready_i |=> $stable(pd_cmd_o.addr))
        else $error("pd_cmd_o.addr changed while stalled");

    // ----------------------------------------
    // Quiet response outputs
    // ----------------------------------------

    a_instr_rdata_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_rsp_o.rvalid |-> instr_rsp_o.rdata == '0)
        else $error("instr rdata not zero without rvalid");

    a_data_rdata_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !data_rsp_o.rvalid |-> data_rsp_o.rdata == '0)
        else $error("data rdata not zero without rvalid");

    a_rvalid_in_reset: assert property (@(posedge clk)
        !rst_n |-> !instr_rsp_o.rvalid && !data_rsp_o.rvalid)
        else $error("rvalid high during reset");

endmodule

bind mem_fabric_top fabric_properties u_props (.*);

// File: tests/fabric_tb.sv
`timescale 1ns/1ps

module fabric_tb;

    // Vector table layout, eight words per line
    localparam int          MAX_VEC  = 64;
    localparam int          FIELDS   = 8;
    localparam int          TIMEOUT  = 50;
    localparam logic [31:0] END_MARK = 32'hff;

    logic clk = 1'b0;
    logic rst_n;

    // Master side
    fabric_bus_pkg::mem_req_t instr_req;
    fabric_bus_pkg::mem_req_t data_req;
    fabric_bus_pkg::mem_rsp_t instr_rsp;
    fabric_bus_pkg::mem_rsp_t data_rsp;

    // ICB side
    fabric_bus_pkg::icb_cmd_t pi_cmd;
    fabric_bus_pkg::icb_cmd_t pd_cmd;
    logic                     pi_ready;
    logic                     pd_ready;
    fabric_bus_pkg::icb_rsp_t pi_rsp;
    fabric_bus_pkg::icb_rsp_t pd_rsp;

    // Slave model bookkeeping
    fabric_bus_pkg::icb_cmd_t pi_last;
    fabric_bus_pkg::icb_cmd_t pd_last;
    int                       pi_acc;
    int                       pd_acc;
    int                       pi_stray;
    int                       pd_stray;

    logic [31:0] vec_mem [MAX_VEC*FIELDS];
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    // ----------------------------------------
    // DUT and ICB slave models
    // ----------------------------------------

    mem_fabric_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_req_i    (instr_req),
        .data_req_i     (data_req),
        .instr_rsp_o    (instr_rsp),
        .data_rsp_o     (data_rsp),
        .pi_cmd_o       (pi_cmd),
        .pi_cmd_ready_i (pi_ready),
        .pi_rsp_i       (pi_rsp),
        .pd_cmd_o       (pd_cmd),
        .pd_cmd_ready_i (pd_ready),
        .pd_rsp_i       (pd_rsp)
    );

    icb_slave_model #(
        .WIN_BASE (fabric_map_pkg::PI_BASE),
        .WIN_MASK (fabric_map_pkg::PI_MASK)
    ) u_pi_slave (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_i      (pi_cmd),
        .ready_o    (pi_ready),
        .rsp_o      (pi_rsp),
        .last_cmd_o (pi_last),
        .accepted_o (pi_acc),
        .stray_o    (pi_stray)
    );

    icb_slave_model #(
        .WIN_BASE (fabric_map_pkg::PD_BASE),
        .WIN_MASK (fabric_map_pkg::PD_MASK)
    ) u_pd_slave (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_i      (pd_cmd),
        .ready_o    (pd_ready),
        .rsp_o      (pd_rsp),
        .last_cmd_o (pd_last),
        .accepted_o (pd_acc),
        .stray_o    (pd_stray)
    );

    // 20 ns period
    initial begin
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    // Idle bus, nothing may be valid
    task automatic check_idle();
        if (instr_rsp.rvalid !== 1'b0)
            report_mismatch("instr_rsp_o.rvalid", 32'(instr_rsp.rvalid), 32'd0);
        if (data_rsp.rvalid !== 1'b0)
            report_mismatch("data_rsp_o.rvalid", 32'(data_rsp.rvalid), 32'd0);
        if (pi_cmd.valid !== 1'b0)
            report_mismatch("pi_cmd_o.valid", 32'(pi_cmd.valid), 32'd0);
        if (pd_cmd.valid !== 1'b0)
            report_mismatch("pd_cmd_o.valid", 32'(pd_cmd.valid), 32'd0);
    endtask

    task automatic finish_test(input int num, input int start_errs);
        tests_run++;
        if (errors != start_errs) begin
            tests_failed++;
            $display("Test %0d failed with %0d errors", num, errors - start_errs);
        end else begin
            $display("Test %0d passed", num);
        end
    endtask

    // One vector: request, grant, response, checks
    task automatic run_vector(input int v);
        fabric_bus_pkg::mem_req_t req;
        fabric_bus_pkg::mem_rsp_t rsp;
        fabric_bus_pkg::icb_cmd_t last;
        string port;
        logic  is_data;
        logic  is_write;
        logic  tgt_tcm;
        logic  tgt_pi;
        logic  tgt_pd;
        logic  exp_gnt;
        int    cycles;
        int    pi_before;
        int    pd_before;
        is_data   = vec_mem[v*FIELDS+1][0];
        is_write  = vec_mem[v*FIELDS+2][0];
        req.req   = 1'b1;
        req.we    = is_write;
        req.addr  = vec_mem[v*FIELDS+3];
        req.be    = vec_mem[v*FIELDS+4][3:0];
        req.wdata = vec_mem[v*FIELDS+5];
        port      = is_data ? "data_rsp_o" : "instr_rsp_o";
        // Target from the memory map
        tgt_tcm   = req.addr[31:15] == 17'h1_0000;
        tgt_pi    = !is_data && req.addr[31:29] == 3'b001;
        tgt_pd    = is_data && req.addr[31:28] == 4'h1;
        pi_before = pi_acc;
        pd_before = pd_acc;

        @(posedge clk);
        #1;
        if (is_data) begin
            data_req = req;
        end else begin
            instr_req = req;
        end

        // TCM grants at once, ICB only while ready
        cycles = 0;
        rsp = '0;
        while (!rsp.gnt && cycles < TIMEOUT) begin
            @(negedge clk);
            rsp = is_data ? data_rsp : instr_rsp;
            exp_gnt = tgt_tcm | (tgt_pi & pi_ready) | (tgt_pd & pd_ready);
            cycles++;
            if (rsp.gnt !== exp_gnt) report_mismatch({port, ".gnt"}, 32'(rsp.gnt), 32'(exp_gnt));
            if (tgt_tcm && (pi_cmd.valid || pd_cmd.valid)) begin
                $display("Vector %0d: TCM request shows up on an ICB bus at %0t", v, $time);
                errors++;
            end
        end
        if (!rsp.gnt) begin
            $display("Vector %0d: no grant within %0d cycles", v, TIMEOUT);
            errors++;
            timed_out = 1'b1;
            return;
        end

        // Transfer at this edge
        @(posedge clk);
        #1;
        instr_req = '0;
        data_req  = '0;

        cycles = 0;
        rsp = '0;
        while (!rsp.rvalid && cycles < TIMEOUT) begin
            @(negedge clk);
            rsp = is_data ? data_rsp : instr_rsp;
            cycles++;
        end
        if (!rsp.rvalid) begin
            $display("Vector %0d: no rvalid within %0d cycles of the grant", v, TIMEOUT);
            errors++;
            timed_out = 1'b1;
            return;
        end

        if (tgt_tcm && cycles != 1) report_mismatch("rvalid latency", 32'(cycles), 32'd1);
        if (!is_write && rsp.rdata !== vec_mem[v*FIELDS+6])
            report_mismatch({port, ".rdata"}, rsp.rdata, vec_mem[v*FIELDS+6]);
        if (rsp.err !== vec_mem[v*FIELDS+7][0])
            report_mismatch({port, ".err"}, 32'(rsp.err), vec_mem[v*FIELDS+7]);

        // Routing: one command on the right bus, none elsewhere
        if (pi_acc !== pi_before + int'(tgt_pi))
            report_mismatch("pi_cmd_o transfers", pi_acc, pi_before + int'(tgt_pi));
        if (pd_acc !== pd_before + int'(tgt_pd))
            report_mismatch("pd_cmd_o transfers", pd_acc, pd_before + int'(tgt_pd));
        if (pi_stray + pd_stray != 0)
            report_mismatch("out of window ICB commands", pi_stray + pd_stray, 32'd0);

        // Command fields as seen by the slave
        last = is_data ? pd_last : pi_last;
        if (tgt_pi || tgt_pd) begin
            if (last.addr !== req.addr) report_mismatch("icb cmd addr", last.addr, req.addr);
            if (last.read !== !is_write)
                report_mismatch("icb cmd read", 32'(last.read), 32'(!is_write));
            if (is_write && last.wdata !== req.wdata)
                report_mismatch("icb cmd wdata", last.wdata, req.wdata);
            if (is_write && last.wmask !== req.be)
                report_mismatch("icb cmd wmask", 32'(last.wmask), 32'(req.be));
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int v;
        int cur_test;
        int start_errs;
        rst_n        = 1'b0;
        instr_req    = '0;
        data_req     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        $readmemh("tests/fabric_vectors.txt", vec_mem);

        // Test 1, idle outputs during and after reset
        start_errs = errors;
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        finish_test(1, start_errs);

        // Vectors, grouped by test number
        v = 0;
        cur_test = vec_mem[0];
        start_errs = errors;
        while (!timed_out && v < MAX_VEC && vec_mem[v*FIELDS] !== END_MARK) begin
            if (vec_mem[v*FIELDS] != cur_test) begin
                finish_test(cur_test, start_errs);
                cur_test = vec_mem[v*FIELDS];
                start_errs = errors;
            end
            run_vector(v);
            v++;
        end
        finish_test(cur_test, start_errs);

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ICB slave with random latency and random back-pressure
module icb_slave_model #(
    parameter fabric_bus_pkg::addr_t WIN_BASE = '0,
    parameter fabric_bus_pkg::addr_t WIN_MASK = '1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fabric_bus_pkg::icb_cmd_t cmd_i,
    output logic                     ready_o,
    output fabric_bus_pkg::icb_rsp_t rsp_o,
    output fabric_bus_pkg::icb_cmd_t last_cmd_o,
    output int                       accepted_o,
    output int                       stray_o
);

    integer seed;
    int     delay;
    logic   busy;
    logic   take;
    logic   in_reset;
    fabric_bus_pkg::icb_cmd_t cmd;

    initial begin
        seed       = 32'h6cc5_ccd4;
        ready_o    = 1'b0;
        rsp_o      = '0;
        last_cmd_o = '0;
        accepted_o = 0;
        stray_o    = 0;
        busy       = 1'b0;
        delay      = 0;
        forever begin
            @(posedge clk);
            // Sample at the edge, drive 1 ns later
            cmd      = cmd_i;
            take     = cmd_i.valid & ready_o;
            in_reset = !rst_n;
            #1;
            rsp_o = '0;
            if (in_reset) begin
                busy = 1'b0;
            end else if (take) begin
                last_cmd_o = cmd;
                accepted_o++;
                if ((cmd.addr & ~WIN_MASK) != (WIN_BASE & ~WIN_MASK)) begin
                    $display("ICB model: command at %h is outside its window", cmd.addr);
                    stray_o++;
                end
                busy  = 1'b1;
                delay = 1 + int'($unsigned($random(seed)) % 32'd4);
            end else if (busy) begin
                delay--;
                if (delay == 0) begin
                    rsp_o.valid = 1'b1;
                    rsp_o.rdata = last_cmd_o.addr ^ 32'ha5a5_5a5a;
                    rsp_o.err   = last_cmd_o.addr[2];
                    busy        = 1'b0;
                end
            end
            // Ready drops about one cycle in four, and while a response is due
            ready_o = !in_reset && !busy && ($unsigned($random(seed)) % 32'd4 != 32'd0);
        end
    end

endmodule

// File: tests/fabric_vectors.txt
// test master(0 instr, 1 data) op(0 read, 1 write) addr be wdata exp_rdata exp_err
// exp_rdata is ignored for writes, a test number of ff ends the list
// Test 2, TCM byte writes through the data port
02 1 1 80000010 f 11223344 00000000 0
02 1 1 80000010 5 aabbccdd 00000000 0
02 1 0 80000010 f 00000000 11bb33dd 0
02 1 0 80007ffc f 00000000 00000000 0
// Test 3, shared TCM in both directions
03 1 1 80000020 f 5a5a1234 00000000 0
03 0 0 80000020 f 00000000 5a5a1234 0
03 0 1 80000040 f 0badf00d 00000000 0
03 0 1 80000040 8 ff000000 00000000 0
03 1 0 80000040 f 00000000 ffadf00d 0
// Test 4, instruction ICB window
04 0 0 20000100 f 00000000 85a55b5a 0
04 0 0 20000104 f 00000000 85a55b5e 1
04 0 1 20000200 c cafef00d 00000000 0
04 0 0 3ffffff0 f 00000000 9a5aa5aa 0
// Test 5, data ICB writes and errors
05 1 1 10000300 f deadbeef 00000000 0
05 1 1 10000304 3 0000abcd 00000000 1
05 1 0 10000200 f 00000000 b5a5585a 0
05 1 0 10000204 f 00000000 b5a5585e 1
// Test 6, routing between TCM and the data ICB
06 1 1 80000100 f 01020304 00000000 0
06 1 0 80000100 f 00000000 01020304 0
06 1 0 1ffffff8 f 00000000 ba5aa5a2 0
06 0 0 80000100 f 00000000 01020304 0
06 1 1 10000008 6 00ffff00 00000000 0
ff 0 0 00000000 0 00000000 00000000 0
